// File: hdl/mips_pkg.sv
package mips_pkg;

	localparam int WORD_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [3:0] alu_op_t;

	localparam word_t RESET_PC = 32'h0000_0000;
	localparam word_t PC_STEP = 32'd4;

	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_ADDIU = 6'b001001;
	localparam opcode_t OP_ANDI = 6'b001100;
	localparam opcode_t OP_ORI = 6'b001101;
	localparam opcode_t OP_XORI = 6'b001110;
	localparam opcode_t OP_SLTI = 6'b001010;
	localparam opcode_t OP_LUI = 6'b001111;
	localparam opcode_t OP_LW = 6'b100011;
	localparam opcode_t OP_SW = 6'b101011;
	localparam opcode_t OP_BEQ = 6'b000100;
	localparam opcode_t OP_BNE = 6'b000101;
	localparam opcode_t OP_J = 6'b000010;

	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND = 6'b100100;
	localparam funct_t FN_OR = 6'b100101;
	localparam funct_t FN_XOR = 6'b100110;
	localparam funct_t FN_NOR = 6'b100111;
	localparam funct_t FN_SLT = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_NOR = 4'd5;
	localparam alu_op_t ALU_SLT = 4'd6;
	localparam alu_op_t ALU_SLTU = 4'd7;
	localparam alu_op_t ALU_LUI = 4'd8;

	// one-hot state encoding
	typedef enum logic [8:0] {
		S_INIT = 9'b000000001,
		S_IF = 9'b000000010,
		S_IW = 9'b000000100,
		S_ID = 9'b000001000,
		S_EX = 9'b000010000,
		S_ST = 9'b000100000,
		S_LD = 9'b001000000,
		S_RDW = 9'b010000000,
		S_WB = 9'b100000000
	} state_t;

	typedef struct packed {
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t imm_ext;
		alu_op_t alu_op;
		logic src2_imm;
		logic reg_write;
		logic is_load;
		logic is_store;
		logic is_branch_eq;
		logic is_branch_ne;
		logic is_jump;
		logic [25:0] jump_index;
	} decoded_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic write;
		logic read;
	} mem_req_t;

endpackage

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
	input word_t a,
	input word_t b,
	input alu_op_t op,
	output word_t result
);

	word_t sum;
	word_t diff;

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		case (op)
			ALU_ADD: result = sum;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: result = {31'b0, a < b};
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = sum;
		endcase
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input reg_addr_t raddr1,
	input reg_addr_t raddr2,
	input reg_addr_t waddr,
	input logic wen,
	input word_t wdata,
	output word_t rdata1,
	output word_t rdata2
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata; // r0 stays zero
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import mips_pkg::*; (
	input word_t inst,
	output decoded_t dec
);

	opcode_t opcode;
	funct_t funct;
	logic zero_ext;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];

	always_comb begin
		dec = '0;
		zero_ext = 1'b0;
		dec.rs = inst[25:21];
		dec.rt = inst[20:16];
		dec.dest = inst[15:11];
		dec.jump_index = inst[25:0];
		dec.alu_op = ALU_ADD;
		case (opcode)
			OP_SPECIAL: begin
				dec.reg_write = 1'b1;
				case (funct)
					FN_ADDU: dec.alu_op = ALU_ADD;
					FN_SUBU: dec.alu_op = ALU_SUB;
					FN_AND: dec.alu_op = ALU_AND;
					FN_OR: dec.alu_op = ALU_OR;
					FN_XOR: dec.alu_op = ALU_XOR;
					FN_NOR: dec.alu_op = ALU_NOR;
					FN_SLT: dec.alu_op = ALU_SLT;
					FN_SLTU: dec.alu_op = ALU_SLTU;
					default: dec.reg_write = 1'b0; // unsupported funct acts as nop
				endcase
			end
			OP_ADDIU: dec.alu_op = ALU_ADD;
			OP_SLTI: dec.alu_op = ALU_SLT;
			OP_ANDI: begin
				dec.alu_op = ALU_AND;
				zero_ext = 1'b1;
			end
			OP_ORI: begin
				dec.alu_op = ALU_OR;
				zero_ext = 1'b1;
			end
			OP_XORI: begin
				dec.alu_op = ALU_XOR;
				zero_ext = 1'b1;
			end
			OP_LUI: dec.alu_op = ALU_LUI;
			OP_LW: dec.is_load = 1'b1;
			OP_SW: dec.is_store = 1'b1;
			OP_BEQ: dec.is_branch_eq = 1'b1;
			OP_BNE: dec.is_branch_ne = 1'b1;
			OP_J: dec.is_jump = 1'b1;
			default: ;
		endcase
		// immediate forms and lw write rt
		if (opcode inside {OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW}) begin
			dec.reg_write = 1'b1;
			dec.src2_imm = 1'b1;
			dec.dest = inst[20:16];
		end
		if (opcode == OP_SW)
			dec.src2_imm = 1'b1;
		dec.imm_ext = zero_ext ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};
	end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input logic ir_load,
	input logic pc_update,
	input logic pc_load,
	input word_t instruction,
	input decoded_t dec,
	input word_t rs_value,
	input word_t rt_value,
	output word_t pc,
	output word_t inst
);

	word_t next_pc;
	word_t pc_plus4;
	word_t br_target;
	word_t jump_target;
	logic br_taken;

	assign pc_plus4 = pc + PC_STEP;
	assign br_target = pc_plus4 + {dec.imm_ext[29:0], 2'b00};
	assign jump_target = {pc[31:28], dec.jump_index, 2'b00};
	assign br_taken = (dec.is_branch_eq && (rs_value == rt_value)) ||
		(dec.is_branch_ne && (rs_value != rt_value));

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
			next_pc <= RESET_PC;
		end else begin
			if (pc_update) begin
				if (dec.is_jump)
					next_pc <= jump_target;
				else if (br_taken)
					next_pc <= br_target;
				else
					next_pc <= pc_plus4;
			end
			if (pc_load)
				pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_load)
			inst <= instruction;
	end

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rd_load,
	input logic mem_write_en,
	input logic mem_read_en,
	input word_t alu_result,
	input word_t rt_value,
	input word_t read_data,
	input decoded_t dec,
	output mem_req_t mem_req,
	output word_t wb_data
);

	word_t read_data_reg;

	always_comb begin
		mem_req.addr = {alu_result[31:2], 2'b00}; // word accesses only
		mem_req.wdata = rt_value;
		mem_req.write = mem_write_en;
		mem_req.read = mem_read_en;
	end

	always_ff @(posedge clk) begin
		if (rst)
			read_data_reg <= '0;
		else if (rd_load)
			read_data_reg <= read_data;
	end

	assign wb_data = dec.is_load ? read_data_reg : alu_result;

endmodule

// File: hdl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input logic inst_req_ack,
	input logic inst_valid,
	input logic mem_req_ack,
	input logic read_data_valid,
	input decoded_t dec,
	output logic inst_req_valid,
	output logic inst_ack,
	output logic read_data_ack,
	output logic mem_write_en,
	output logic mem_read_en,
	output logic ir_load,
	output logic pc_update,
	output logic pc_load,
	output logic rf_wen,
	output logic rd_load
);

	state_t state;
	state_t next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= S_INIT;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			S_INIT: next_state = S_IF;
			S_IF: if (inst_req_ack) next_state = S_IW;
			S_IW: if (inst_valid) next_state = S_ID;
			S_ID: next_state = S_EX;
			S_EX: begin
				if (dec.is_branch_eq || dec.is_branch_ne || dec.is_jump)
					next_state = S_IF; // no write-back for control flow
				else if (dec.is_store)
					next_state = S_ST;
				else if (dec.is_load)
					next_state = S_LD;
				else
					next_state = S_WB;
			end
			S_ST: if (mem_req_ack) next_state = S_IF;
			S_LD: if (mem_req_ack) next_state = S_RDW;
			S_RDW: if (read_data_valid) next_state = S_WB;
			S_WB: next_state = S_IF;
			default: next_state = S_INIT;
		endcase
	end

	assign inst_req_valid = (state == S_IF);
	assign inst_ack = (state == S_IW);
	assign read_data_ack = (state == S_RDW);
	assign mem_write_en = (state == S_ST);
	assign mem_read_en = (state == S_LD);
	assign ir_load = (state == S_IW) && inst_valid;
	assign pc_update = (state == S_ID);
	assign pc_load = (next_state == S_IF) && (state != S_IF); // entry into fetch only
	assign rf_wen = (state == S_WB) && dec.reg_write;
	assign rd_load = (state == S_RDW) && read_data_valid;

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
	input logic clk,
	input logic rst,
	output word_t pc,
	output logic inst_req_valid,
	input logic inst_req_ack,
	input word_t instruction,
	input logic inst_valid,
	output logic inst_ack,
	output mem_req_t mem_req,
	input logic mem_req_ack,
	input word_t read_data,
	input logic read_data_valid,
	output logic read_data_ack
);

	decoded_t dec;
	word_t inst;
	word_t rs_value;
	word_t rt_value;
	word_t alu_b;
	word_t alu_result;
	word_t wb_data;
	logic mem_write_en;
	logic mem_read_en;
	logic ir_load;
	logic pc_update;
	logic pc_load;
	logic rf_wen;
	logic rd_load;

	assign alu_b = dec.src2_imm ? dec.imm_ext : rt_value;

	cpu_control u_control (
		.clk(clk), .rst(rst),
		.inst_req_ack(inst_req_ack), .inst_valid(inst_valid),
		.mem_req_ack(mem_req_ack), .read_data_valid(read_data_valid),
		.dec(dec),
		.inst_req_valid(inst_req_valid), .inst_ack(inst_ack),
		.read_data_ack(read_data_ack),
		.mem_write_en(mem_write_en), .mem_read_en(mem_read_en),
		.ir_load(ir_load), .pc_update(pc_update), .pc_load(pc_load),
		.rf_wen(rf_wen), .rd_load(rd_load)
	);

	fetch_unit u_fetch (
		.clk(clk), .rst(rst),
		.ir_load(ir_load), .pc_update(pc_update), .pc_load(pc_load),
		.instruction(instruction), .dec(dec),
		.rs_value(rs_value), .rt_value(rt_value),
		.pc(pc), .inst(inst)
	);

	inst_decoder u_decoder (.inst(inst), .dec(dec));

	reg_file u_regs (
		.clk(clk), .rst(rst),
		.raddr1(dec.rs), .raddr2(dec.rt), .waddr(dec.dest),
		.wen(rf_wen), .wdata(wb_data),
		.rdata1(rs_value), .rdata2(rt_value)
	);

	alu u_alu (.a(rs_value), .b(alu_b), .op(dec.alu_op), .result(alu_result));

	mem_stage u_mem (
		.clk(clk), .rst(rst),
		.rd_load(rd_load), .mem_write_en(mem_write_en), .mem_read_en(mem_read_en),
		.alu_result(alu_result), .rt_value(rt_value), .read_data(read_data),
		.dec(dec), .mem_req(mem_req), .wb_data(wb_data)
	);

endmodule

// File: testbench/mips_chk.sv
`timescale 1ns/1ps

module mips_chk import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input word_t pc,
	input logic inst_req_valid,
	input logic inst_req_ack,
	input logic inst_ack,
	input mem_req_t mem_req,
	input logic mem_req_ack,
	input logic read_data_ack
);

	int fail_count = 0; // read by the testbench top

	fetch_held: assert property (@(posedge clk) disable iff (rst)
		inst_req_valid && !inst_req_ack |=> inst_req_valid && $stable(pc))
		else begin
			$error("fetch request dropped or pc changed before ack");
			fail_count++;
		end

	mem_req_held: assert property (@(posedge clk) disable iff (rst)
		(mem_req.write || mem_req.read) && !mem_req_ack |=> $stable(mem_req))
		else begin
			$error("data request changed before ack");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk)
		$past(rst) |-> !inst_req_valid && !inst_ack && !mem_req.write && !mem_req.read
			&& !read_data_ack && (pc == RESET_PC))
		else begin
			$error("control outputs not idle after reset");
			fail_count++;
		end

endmodule

bind mips_core mips_chk u_chk (
	.clk(clk), .rst(rst), .pc(pc),
	.inst_req_valid(inst_req_valid), .inst_req_ack(inst_req_ack), .inst_ack(inst_ack),
	.mem_req(mem_req), .mem_req_ack(mem_req_ack), .read_data_ack(read_data_ack)
);

// File: testbench/mips_monitor.sv
`timescale 1ns/1ps

module mips_monitor import mips_pkg::*; (
	input logic clk,
	input logic rst,
	input word_t pc,
	input logic inst_req_valid,
	input logic inst_req_ack,
	input mem_req_t mem_req,
	input logic mem_req_ack,
	output logic done,
	output logic timed_out,
	output int err_count,
	output int check_count
);

	logic ev_store [128]; // 0 fetch, 1 store
	word_t ev_addr [128];
	word_t ev_data [128];
	int ev_group [128];
	int n_ev = 0;
	int n_fetch = 0;
	int idx = 0;
	int cycles = 0;
	int group_errs = 0;
	int group_checks = 0;
	logic done_r = 1'b0;
	logic timeout_r = 1'b0;
	int errs = 0;
	int checks = 0;

	word_t rtype_vals [8] = '{32'h80000008, 32'h7ffffffe, 32'h00000001, 32'h80000007,
		32'h80000006, 32'h7ffffff8, 32'h00000001, 32'h00000000};
	word_t imm_vals [6] = '{32'hfffffff0, 32'h00000001, 32'h00008f00, 32'h00009234,
		32'hffffff0f, 32'h12340000};

	assign done = done_r;
	assign timed_out = timeout_r;
	assign err_count = errs;
	assign check_count = checks;

	task automatic add_event(input logic st, input word_t a, input word_t d, input int g);
		ev_store[n_ev] = st;
		ev_addr[n_ev] = a;
		ev_data[n_ev] = d;
		ev_group[n_ev] = g;
		n_ev++;
		if (!st)
			n_fetch++;
	endtask

	// an op, the sw after it, and the store that the sw makes
	task automatic add_op_store(input word_t op_addr, input word_t st_addr, input word_t val,
		input int g);
		add_event(1'b0, op_addr, '0, g);
		add_event(1'b0, op_addr + 32'd4, '0, g);
		add_event(1'b1, st_addr, val, g);
	endtask

	function automatic string group_name(input int g);
		case (g)
			1: return "r-type";
			2: return "immediates";
			3: return "load-store";
			4: return "control flow";
			5: return "register zero";
			default: return "back-pressure";
		endcase
	endfunction

	initial begin
		for (int a = 0; a < 12; a += 4)
			add_event(1'b0, word_t'(a), '0, 1);
		for (int k = 0; k < 8; k++)
			add_op_store(word_t'(32'h0c + 8 * k), word_t'(32'h100 + 4 * k), rtype_vals[k], 1);
		for (int k = 0; k < 6; k++)
			add_op_store(word_t'(32'h4c + 8 * k), word_t'(32'h120 + 4 * k), imm_vals[k], 2);
		add_op_store(32'h7c, 32'h138, 32'h80de64c0, 3);
		add_op_store(32'h84, 32'h13c, 32'h84de6b0c, 3);
		add_event(1'b0, 32'h8c, '0, 4); // beq taken
		add_event(1'b0, 32'h98, '0, 4);
		add_event(1'b0, 32'h9c, '0, 4); // bne taken
		add_event(1'b0, 32'ha4, '0, 4);
		add_event(1'b0, 32'ha8, '0, 4); // j
		add_op_store(32'hb4, 32'h140, 32'h00000055, 4);
		add_event(1'b0, 32'hbc, '0, 5);
		add_op_store(32'hc0, 32'h144, 32'h00000000, 5);
		add_event(1'b0, 32'hc8, '0, 5);
	end

	task automatic advance();
		idx++;
		checks++;
		group_checks++;
		if (idx == n_ev || ev_group[idx] != ev_group[idx-1]) begin
			$display("test %0d %s: %0d checks, %0d errors", ev_group[idx-1],
				group_name(ev_group[idx-1]), group_checks, group_errs);
			group_checks = 0;
			group_errs = 0;
		end
		if (idx == n_ev) begin
			$display("test 6 %s: %0d events seen once and in order, %0d errors",
				group_name(6), checks, errs);
			done_r = 1'b1;
		end
	endtask

	task automatic fail_one();
		errs++;
		group_errs++;
	endtask

	always @(posedge clk) begin
		if (!rst && !done_r && !timeout_r) begin
			cycles++;
			if (inst_req_valid && inst_req_ack) begin
				if (ev_store[idx]) begin
					$display("fetch at %h seen where a store to %h was expected",
						pc, ev_addr[idx]);
					fail_one();
				end else if (pc != ev_addr[idx]) begin
					$display("ERR pc expected %h actual %h", ev_addr[idx], pc);
					fail_one();
				end
				advance();
			end else if (mem_req.write && mem_req_ack) begin
				if (!ev_store[idx]) begin
					$display("store to %h seen where a fetch at %h was expected",
						mem_req.addr, ev_addr[idx]);
					fail_one();
				end else begin
					if (mem_req.addr != ev_addr[idx]) begin
						$display("ERR mem_req.addr expected %h actual %h",
							ev_addr[idx], mem_req.addr);
						fail_one();
					end
					if (mem_req.wdata != ev_data[idx]) begin
						$display("ERR mem_req.wdata expected %h actual %h",
							ev_data[idx], mem_req.wdata);
						fail_one();
					end
				end
				advance();
			end
			if (!done_r && cycles >= n_fetch * 20) begin
				$display("core stopped making progress: %0d of %0d events after %0d cycles",
					idx, n_ev, cycles);
				timeout_r = 1'b1;
			end
		end
	end

endmodule

// File: testbench/tb_mips.sv
`timescale 1ns/1ps

module tb_mips import mips_pkg::*;;

	logic clk = 1'b0;
	logic rst = 1'b1;
	word_t pc;
	logic inst_req_valid;
	logic inst_req_ack = 1'b0;
	word_t instruction = '0;
	logic inst_valid = 1'b0;
	logic inst_ack;
	mem_req_t mem_req;
	logic mem_req_ack = 1'b0;
	word_t read_data = '0;
	logic read_data_valid = 1'b0;
	logic read_data_ack;

	logic done;
	logic timed_out;
	int err_count;
	int check_count;
	int total_errs;

	word_t imem [256];
	word_t dmem [256];
	logic [31:0] rng = 32'h2799753c;

	// address, instruction
	logic [63:0] prog [51] = '{
		64'h00000000_3c018000, 64'h00000004_34210005, 64'h00000008_24020003,
		64'h0000000c_00221821, 64'h00000010_ac030100, 64'h00000014_00411823,
		64'h00000018_ac030104, 64'h0000001c_00221824, 64'h00000020_ac030108,
		64'h00000024_00221825, 64'h00000028_ac03010c, 64'h0000002c_00221826,
		64'h00000030_ac030110, 64'h00000034_00221827, 64'h00000038_ac030114,
		64'h0000003c_0022182a, 64'h00000040_ac030118, 64'h00000044_0022182b,
		64'h00000048_ac03011c, 64'h0000004c_2404fff0, 64'h00000050_ac040120,
		64'h00000054_2885ffff, 64'h00000058_ac050124, 64'h0000005c_30858f0f,
		64'h00000060_ac050128, 64'h00000064_34059234, 64'h00000068_ac05012c,
		64'h0000006c_388500ff, 64'h00000070_ac050130, 64'h00000074_3c051234,
		64'h00000078_ac050134, 64'h0000007c_8c060040, 64'h00000080_ac060138,
		64'h00000084_8c470041, 64'h00000088_ac07013c, 64'h0000008c_10420002,
		64'h00000090_ac0201f0, 64'h00000094_ac0201f4, 64'h00000098_10220001,
		64'h0000009c_14220001, 64'h000000a0_ac0201f8, 64'h000000a4_14420001,
		64'h000000a8_0800002d, 64'h000000ac_ac0201fc, 64'h000000b0_ac0201fc,
		64'h000000b4_24080055, 64'h000000b8_ac080140, 64'h000000bc_24001234,
		64'h000000c0_00220021, 64'h000000c4_ac000144, 64'h000000c8_08000032
	};

	mips_core mips_core_i (
		.clk(clk), .rst(rst), .pc(pc),
		.inst_req_valid(inst_req_valid), .inst_req_ack(inst_req_ack),
		.instruction(instruction), .inst_valid(inst_valid), .inst_ack(inst_ack),
		.mem_req(mem_req), .mem_req_ack(mem_req_ack),
		.read_data(read_data), .read_data_valid(read_data_valid),
		.read_data_ack(read_data_ack)
	);

	mips_monitor monitor_i (
		.clk(clk), .rst(rst), .pc(pc),
		.inst_req_valid(inst_req_valid), .inst_req_ack(inst_req_ack),
		.mem_req(mem_req), .mem_req_ack(mem_req_ack),
		.done(done), .timed_out(timed_out), .err_count(err_count), .check_count(check_count)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic idle_cycles();
		int d;
		rng = xorshift32(rng);
		d = int'(rng[1:0]); // 0 to 3
		repeat (d) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		for (int i = 0; i < 256; i++) begin
			imem[i] = {6'b000010, 26'(i)}; // stray fetch spins on itself
			dmem[i] = (word_t'(i * 4) * 32'h01000193) ^ 32'hc0de0000;
		end
		foreach (prog[r])
			imem[prog[r][41:34]] = prog[r][31:0];
	end

	// instruction side
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (inst_req_valid) begin
				idle_cycles();
				inst_req_ack = 1'b1;
				instruction = imem[pc[9:2]];
				@(posedge clk);
				#1;
				inst_req_ack = 1'b0;
				idle_cycles();
				inst_valid = 1'b1;
				while (!inst_ack) begin
					@(posedge clk);
					#1;
				end
				@(posedge clk);
				#1;
				inst_valid = 1'b0;
			end
		end
	end

	// data side
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (mem_req.write || mem_req.read) begin
				idle_cycles();
				mem_req_ack = 1'b1;
				if (mem_req.write)
					dmem[mem_req.addr[9:2]] = mem_req.wdata;
				else
					read_data = dmem[mem_req.addr[9:2]];
				@(posedge clk);
				#1;
				mem_req_ack = 1'b0;
				if (read_data_ack) begin
					idle_cycles();
					read_data_valid = 1'b1;
					@(posedge clk);
					#1;
					read_data_valid = 1'b0;
				end
			end
		end
	end

	initial begin
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		while (!done && !timed_out)
			@(posedge clk);
		@(posedge clk);
		total_errs = err_count + mips_core_i.u_chk.fail_count;
		$display("checks %0d, value errors %0d, assertion failures %0d", check_count,
			err_count, mips_core_i.u_chk.fail_count);
		if (timed_out || total_errs != 0) begin
			$display("Test FAILED");
		end else begin
			$display("Test OK");
		end
		$finish;
	end

endmodule

// File: project.f
hdl/mips_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/inst_decoder.sv
hdl/fetch_unit.sv
hdl/mem_stage.sv
hdl/cpu_control.sv
hdl/mips_core.sv
testbench/mips_chk.sv
testbench/mips_monitor.sv
testbench/tb_mips.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_mips
FILELIST = project.f
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)
